/* files.f */
obi_pkg.sv
bus_map_pkg.sv
obi_if.sv
obi_addr_demux.sv
obi_rr_arbiter.sv
obi_sram.sv
ext_bus_top.sv
tb_ext_bus.sv

/* run.sh */
#!/bin/sh
# Build and run the bus simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_ext_bus -o sim_ext_bus
./obj_dir/sim_ext_bus

/* tb_ext_bus.sv */
// Testbench for the peripheral bus top level
// Manager sequencers, external subordinate model, reference memories
// and response checks

`timescale 1ns/1ps
`default_nettype none

module tb_ext_bus
  import obi_pkg::*;
  import bus_map_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_TXN = 16 + 40 + 30 + 120;
  localparam obi_addr_t EXT_BASE = 32'h1000_0000;

  typedef struct packed {
    logic        rd;
    logic        sram;
    int unsigned cyc;
    obi_data_t   data;
  } resp_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      m_req [2];
  obi_addr_t m_addr [2];
  logic      m_we [2];
  obi_be_t   m_be [2];
  obi_data_t m_wdata [2];
  logic      m_gnt [2];
  logic      m_rvalid [2];
  obi_data_t m_rdata [2];
  logic      ext_req_o;
  logic      ext_we_o;
  obi_addr_t ext_addr_o;
  obi_be_t   ext_be_o;
  obi_data_t ext_wdata_o;
  logic      ext_gnt_i = 1'b0;
  logic      ext_rvalid_i = 1'b0;
  obi_data_t ext_rdata_i = '0;

  int unsigned lcg_state = 82203;
  int unsigned cyc = 0;
  logic        stall = 1'b0;
  logic        alt_phase = 1'b0;
  obi_data_t   sram_ref [16];
  obi_data_t   ext_ref [16];
  obi_data_t   ext_mem [16];
  resp_t       exp_q [2][$];
  obi_data_t   ext_resp [$];
  int unsigned rwait = 0;

  ext_bus_top UUT (
    .clk_i, .rst_ni,
    .m0_req_i (m_req[0]), .m0_addr_i (m_addr[0]), .m0_we_i (m_we[0]),
    .m0_be_i (m_be[0]), .m0_wdata_i (m_wdata[0]), .m0_gnt_o (m_gnt[0]),
    .m0_rvalid_o (m_rvalid[0]), .m0_rdata_o (m_rdata[0]),
    .m1_req_i (m_req[1]), .m1_addr_i (m_addr[1]), .m1_we_i (m_we[1]),
    .m1_be_i (m_be[1]), .m1_wdata_i (m_wdata[1]), .m1_gnt_o (m_gnt[1]),
    .m1_rvalid_o (m_rvalid[1]), .m1_rdata_o (m_rdata[1]),
    .ext_req_o, .ext_addr_o, .ext_we_o, .ext_be_o, .ext_wdata_o,
    .ext_gnt_i, .ext_rvalid_i, .ext_rdata_i
  );

  initial begin : clock_gen
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic int unsigned lcg();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic obi_data_t rand_word();
    obi_data_t w;
    w[31:16] = 16'(lcg());
    w[15:0]  = 16'(lcg());
    return w;
  endfunction

  function automatic obi_data_t merge(obi_data_t old, obi_data_t wd, obi_be_t be);
    obi_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic abort_test(string what);
    $display("At %0t: %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  // Manager sequencer
  // --------------------
  task automatic issue(int m, obi_addr_t addr, logic we, obi_be_t be, obi_data_t wd);
    @(posedge clk_i);
    m_req[m]   <= 1'b1;
    m_addr[m]  <= addr;
    m_we[m]    <= we;
    m_be[m]    <= be;
    m_wdata[m] <= wd;
    do @(negedge clk_i); while (!m_gnt[m]);
  endtask

  // Mode 0 SRAM only, 1 external only, 2 mixed
  task automatic run_txns(int m, int n, int mode);
    logic      ext;
    obi_addr_t addr;
    for (int i = 0; i < n; i++) begin
      ext  = (mode == 1) || (mode == 2 && lcg() % 2 == 1);
      addr = {30'(lcg() % 16), 2'b00};
      if (ext) addr = EXT_BASE + addr;
      issue(m, addr, lcg() % 2 == 1, obi_be_t'(lcg() % 15 + 1), rand_word());
    end
    @(posedge clk_i);
    m_req[m] <= 1'b0;
  endtask

  // External subordinate model
  // --------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ext_gnt_i    <= 1'b0;
      ext_rvalid_i <= 1'b0;
    end else begin
      ext_gnt_i <= stall ? (lcg() % 4 == 0) : (lcg() % 4 != 0);
      if (rwait > 0) begin
        rwait = rwait - 1;
        ext_rvalid_i <= 1'b0;
      end else if (ext_resp.size() > 0) begin
        ext_rvalid_i <= 1'b1;
        ext_rdata_i  <= ext_resp.pop_front();
        rwait = lcg() % 3;
      end else begin
        ext_rvalid_i <= 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && ext_req_o && ext_gnt_i) begin
      ext_resp.push_back(ext_mem[ext_addr_o[5:2]]);
      if (ext_we_o) begin
        ext_mem[ext_addr_o[5:2]] = merge(ext_mem[ext_addr_o[5:2]], ext_wdata_o, ext_be_o);
      end
    end
  end

  // Checks sampled mid-cycle
  // --------------------
  logic rst_prev = 1'b0;
  logic prev_both = 1'b0;
  logic last_g = 1'b0;

  always @(negedge clk_i) begin : monitor
    resp_t e;
    int    idx;
    if (!rst_ni || !rst_prev) begin
      assert (!m_rvalid[0] && !m_rvalid[1] && !ext_req_o)
        else abort_test("rvalid or ext_req_o high during or right after reset");
    end
    rst_prev = rst_ni;
    for (int m = 0; m < 2; m++) begin
      if (rst_ni && m_req[m] && m_gnt[m]) begin
        idx    = int'(m_addr[m][5:2]);
        e.rd   = !m_we[m];
        e.cyc  = cyc;
        e.sram = m_addr[m] < SRAM_SIZE;
        if (e.sram) begin
          e.data = sram_ref[idx];
          if (m_we[m]) sram_ref[idx] = merge(sram_ref[idx], m_wdata[m], m_be[m]);
        end else begin
          e.data = ext_ref[idx];
          if (m_we[m]) ext_ref[idx] = merge(ext_ref[idx], m_wdata[m], m_be[m]);
          assert (ext_req_o && ext_gnt_i) else abort_test("external handshake missing");
          assert (ext_addr_o == m_addr[m])
            else report_mismatch("ext_addr_o", ext_addr_o, m_addr[m]);
          assert (ext_wdata_o == m_wdata[m])
            else report_mismatch("ext_wdata_o", ext_wdata_o, m_wdata[m]);
          assert ({ext_we_o, ext_be_o} == {m_we[m], m_be[m]})
            else report_mismatch("ext_we_o/ext_be_o", 32'({ext_we_o, ext_be_o}),
                                 32'({m_we[m], m_be[m]}));
        end
        exp_q[m].push_back(e);
      end
      if (m_rvalid[m]) begin
        assert (exp_q[m].size() > 0) else abort_test("response without a pending request");
        e = exp_q[m].pop_front();
        if (e.rd) begin
          assert (m_rdata[m] == e.data)
            else report_mismatch(m == 0 ? "m0_rdata_o" : "m1_rdata_o", m_rdata[m], e.data);
        end
        if (e.sram) begin
          assert (cyc == e.cyc + 1)
            else report_mismatch(m == 0 ? "m0_rvalid_o cycle" : "m1_rvalid_o cycle",
                                 cyc, e.cyc + 1);
        end
      end
    end
    // Both managers streaming into the SRAM
    if (alt_phase && m_req[0] && m_req[1]) begin
      assert (m_gnt[0] ^ m_gnt[1])
        else abort_test("SRAM grant not given to exactly one manager");
      if (prev_both) begin
        assert (m_gnt[1] != last_g) else abort_test("SRAM grants did not alternate");
      end
      last_g    = m_gnt[1];
      prev_both = 1'b1;
    end else begin
      prev_both = 1'b0;
    end
  end

  initial begin : watchdog
    #(N_TXN * 20 * CLK_PERIOD);
    $display("Timeout: transactions did not complete in time");
    $display("Test failed");
    $fatal(1);
  end

  initial begin : main
    rst_ni = 1'b0;
    for (int m = 0; m < 2; m++) begin
      m_req[m] = 1'b0;
      m_addr[m] = '0;
      m_we[m] = 1'b0;
      m_be[m] = '0;
      m_wdata[m] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      ext_mem[i] = {16'(EXT_BASE[31:16] + i * 4), ~16'(i * 4)};
      ext_ref[i] = ext_mem[i];
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Fill the SRAM words that are used
    for (int i = 0; i < 16; i++) begin
      issue(0, obi_addr_t'(i * 4), 1'b1, 4'hf, lcg() * 32'h9e37 + i);
    end
    @(posedge clk_i);
    m_req[0] <= 1'b0;
    alt_phase = 1'b1;
    fork
      run_txns(0, 20, 0);
      run_txns(1, 20, 0);
    join
    alt_phase = 1'b0;
    stall = 1'b1;
    fork
      run_txns(0, 10, 1);
      run_txns(1, 20, 0);
    join
    stall = 1'b0;
    fork
      run_txns(0, 60, 2);
      run_txns(1, 60, 2);
    join
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* ext_bus_top.sv */
// Peripheral bus top level
// Two managers, one address demux each, per-target arbiters,
// on-chip SRAM and one external subordinate port

`timescale 1ns/1ps
`default_nettype none

module ext_bus_top
  import obi_pkg::*;
  import bus_map_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Manager 0
  input  logic      m0_req_i,
  input  obi_addr_t m0_addr_i,
  input  logic      m0_we_i,
  input  obi_be_t   m0_be_i,
  input  obi_data_t m0_wdata_i,
  output logic      m0_gnt_o,
  output logic      m0_rvalid_o,
  output obi_data_t m0_rdata_o,

  // Manager 1
  input  logic      m1_req_i,
  input  obi_addr_t m1_addr_i,
  input  logic      m1_we_i,
  input  obi_be_t   m1_be_i,
  input  obi_data_t m1_wdata_i,
  output logic      m1_gnt_o,
  output logic      m1_rvalid_o,
  output obi_data_t m1_rdata_o,

  // External subordinate
  output logic      ext_req_o,
  output obi_addr_t ext_addr_o,
  output logic      ext_we_o,
  output obi_be_t   ext_be_o,
  output obi_data_t ext_wdata_o,
  input  logic      ext_gnt_i,
  input  logic      ext_rvalid_i,
  input  obi_data_t ext_rdata_i
);

  obi_if mgr_if     [NUM_MANAGERS] ();
  obi_if sram_in_if [NUM_MANAGERS] ();
  obi_if ext_in_if  [NUM_MANAGERS] ();
  obi_if sram_if ();
  obi_if ext_if ();

  // Manager ports
  // --------------------
  assign mgr_if[0].req   = m0_req_i;
  assign mgr_if[0].addr  = m0_addr_i;
  assign mgr_if[0].we    = m0_we_i;
  assign mgr_if[0].be    = m0_be_i;
  assign mgr_if[0].wdata = m0_wdata_i;
  assign m0_gnt_o        = mgr_if[0].gnt;
  assign m0_rvalid_o     = mgr_if[0].rvalid;
  assign m0_rdata_o      = mgr_if[0].rdata;

  assign mgr_if[1].req   = m1_req_i;
  assign mgr_if[1].addr  = m1_addr_i;
  assign mgr_if[1].we    = m1_we_i;
  assign mgr_if[1].be    = m1_be_i;
  assign mgr_if[1].wdata = m1_wdata_i;
  assign m1_gnt_o        = mgr_if[1].gnt;
  assign m1_rvalid_o     = mgr_if[1].rvalid;
  assign m1_rdata_o      = mgr_if[1].rdata;

  // Demux per manager
  // --------------------
  for (genvar m = 0; m < NUM_MANAGERS; m++) begin : gen_mgr
    obi_if dmx_if [NUM_TARGETS] ();

    obi_addr_demux u_demux (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .mgr_i  (mgr_if[m]),
      .tgt_o  (dmx_if)
    );

    // SRAM side
    assign sram_in_if[m].req   = dmx_if[TARGET_SRAM_IDX].req;
    assign sram_in_if[m].addr  = dmx_if[TARGET_SRAM_IDX].addr;
    assign sram_in_if[m].we    = dmx_if[TARGET_SRAM_IDX].we;
    assign sram_in_if[m].be    = dmx_if[TARGET_SRAM_IDX].be;
    assign sram_in_if[m].wdata = dmx_if[TARGET_SRAM_IDX].wdata;
    assign dmx_if[TARGET_SRAM_IDX].gnt    = sram_in_if[m].gnt;
    assign dmx_if[TARGET_SRAM_IDX].rvalid = sram_in_if[m].rvalid;
    assign dmx_if[TARGET_SRAM_IDX].rdata  = sram_in_if[m].rdata;

    // External side
    assign ext_in_if[m].req   = dmx_if[TARGET_EXT_IDX].req;
    assign ext_in_if[m].addr  = dmx_if[TARGET_EXT_IDX].addr;
    assign ext_in_if[m].we    = dmx_if[TARGET_EXT_IDX].we;
    assign ext_in_if[m].be    = dmx_if[TARGET_EXT_IDX].be;
    assign ext_in_if[m].wdata = dmx_if[TARGET_EXT_IDX].wdata;
    assign dmx_if[TARGET_EXT_IDX].gnt    = ext_in_if[m].gnt;
    assign dmx_if[TARGET_EXT_IDX].rvalid = ext_in_if[m].rvalid;
    assign dmx_if[TARGET_EXT_IDX].rdata  = ext_in_if[m].rdata;
  end

  // Targets
  // --------------------
  obi_rr_arbiter sram_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mgr_i  (sram_in_if),
    .sub_o  (sram_if)
  );

  obi_sram u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (sram_if)
  );

  obi_rr_arbiter ext_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mgr_i  (ext_in_if),
    .sub_o  (ext_if)
  );

  assign ext_req_o     = ext_if.req;
  assign ext_addr_o    = ext_if.addr;
  assign ext_we_o      = ext_if.we;
  assign ext_be_o      = ext_if.be;
  assign ext_wdata_o   = ext_if.wdata;
  assign ext_if.gnt    = ext_gnt_i;
  assign ext_if.rvalid = ext_rvalid_i;
  assign ext_if.rdata  = ext_rdata_i;

endmodule

`default_nettype wire

/* obi_sram.sv */
// Word-addressed SRAM on an OBI subordinate port
// Byte-enabled writes, registered reads with one cycle latency

`timescale 1ns/1ps
`default_nettype none

module obi_sram
  import obi_pkg::*;
  import bus_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  obi_if.subordinate bus_i
);

  sram_idx_t word_idx;
  obi_data_t mem_q [SRAM_WORDS];
  obi_data_t rdata_q;
  logic      rvalid_q;

  assign word_idx = bus_i.addr[OBI_BYTE_OFS_W +: SRAM_IDX_W];

  // Always ready
  assign bus_i.gnt    = 1'b1;
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

  // Array access
  // --------------------
  always_ff @(posedge clk_i) begin : mem_access
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int b = 0; b < OBI_BE_W; b++) begin
          if (bus_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // One response per accepted request, writes included
  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_valid
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

endmodule

`default_nettype wire

/* obi_rr_arbiter.sv */
// Two-to-one OBI round-robin arbiter
// Grant index queue routes responses back in acceptance order

`timescale 1ns/1ps
`default_nettype none

module obi_rr_arbiter
  import obi_pkg::*;
  import bus_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  obi_if.subordinate mgr_i [NUM_MANAGERS],
  obi_if.manager     sub_o
);

  logic [NUM_MANAGERS-1:0] mgr_req;
  logic [NUM_MANAGERS-1:0] mgr_we;
  obi_addr_t               mgr_addr  [NUM_MANAGERS];
  obi_be_t                 mgr_be    [NUM_MANAGERS];
  obi_data_t               mgr_wdata [NUM_MANAGERS];

  mgr_idx_t rr_q;
  mgr_idx_t arb_idx;
  mgr_idx_t sel_idx;
  mgr_idx_t lock_idx_q;
  logic     lock_q;

  mgr_idx_t   fifo_q [MAX_OUTSTANDING];
  qptr_t      wr_ptr_q;
  qptr_t      rd_ptr_q;
  outst_cnt_t fill_q;
  mgr_idx_t   head;
  logic       full;
  logic       empty;
  logic       push;
  logic       pop;

  for (genvar m = 0; m < NUM_MANAGERS; m++) begin : gen_mgr
    assign mgr_req[m]   = mgr_i[m].req;
    assign mgr_we[m]    = mgr_i[m].we;
    assign mgr_addr[m]  = mgr_i[m].addr;
    assign mgr_be[m]    = mgr_i[m].be;
    assign mgr_wdata[m] = mgr_i[m].wdata;

    assign mgr_i[m].gnt    = sub_o.gnt && !full && mgr_req[m] && (sel_idx == mgr_idx_t'(m));
    assign mgr_i[m].rvalid = sub_o.rvalid && (head == mgr_idx_t'(m));
    assign mgr_i[m].rdata  = sub_o.rdata;
  end

  // Arbitration
  // --------------------
  // Walk from lowest to highest priority so the last hit wins
  always_comb begin : rr_pick
    mgr_idx_t cand;
    arb_idx = rr_q;
    for (int i = NUM_MANAGERS - 1; i >= 0; i--) begin
      cand = rr_q + mgr_idx_t'(i);
      if (mgr_req[cand]) begin
        arb_idx = cand;
      end
    end
  end

  // A stalled request keeps its manager so the bus fields stay stable
  assign sel_idx = lock_q ? lock_idx_q : arb_idx;

  assign sub_o.req   = (|mgr_req) && !full;
  assign sub_o.addr  = mgr_addr[sel_idx];
  assign sub_o.we    = mgr_we[sel_idx];
  assign sub_o.be    = mgr_be[sel_idx];
  assign sub_o.wdata = mgr_wdata[sel_idx];

  // Response index queue
  // --------------------
  assign full  = (fill_q == outst_cnt_t'(MAX_OUTSTANDING));
  assign empty = (fill_q == '0);
  assign push  = sub_o.req && sub_o.gnt;
  assign pop   = sub_o.rvalid;
  assign head  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      rr_q     <= '0;
      lock_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      lock_q <= sub_o.req && !sub_o.gnt;
      if (push) begin
        rr_q     <= sel_idx + 1'b1;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push && pop) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : queue_store
    lock_idx_q <= sel_idx;
    if (push) begin
      fifo_q[wr_ptr_q] <= sel_idx;
    end
  end

  // Fill count stays in range and agrees with the pointer distance
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (fill_q <= outst_cnt_t'(MAX_OUTSTANDING)) && ((wr_ptr_q - rd_ptr_q) == qptr_t'(fill_q))
  );

  // Subordinate answers only what it has accepted
  a_no_rvalid_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    sub_o.rvalid |-> !empty
  );

endmodule

`default_nettype wire

/* obi_addr_demux.sv */
// One-to-two OBI address demux
// Steers a manager to the SRAM or the external target and
// returns responses from the target of the pending transactions

`timescale 1ns/1ps
`default_nettype none

module obi_addr_demux
  import obi_pkg::*;
  import bus_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  obi_if.subordinate mgr_i,
  obi_if.manager     tgt_o [NUM_TARGETS]
);

  target_idx_t sel;
  target_idx_t tgt_q;
  outst_cnt_t  cnt_q;
  logic        at_max;
  logic        hold;
  logic        accept;

  logic [NUM_TARGETS-1:0] tgt_gnt;
  logic [NUM_TARGETS-1:0] tgt_rvalid;
  obi_data_t              tgt_rdata [NUM_TARGETS];

  // Decode and stall
  // --------------------
  assign sel    = addr_to_target(mgr_i.addr);
  assign at_max = (cnt_q == outst_cnt_t'(MAX_OUTSTANDING));

  // A target switch waits until the old target has answered everything
  assign hold = at_max || ((cnt_q != '0) && (sel != tgt_q));

  for (genvar t = 0; t < NUM_TARGETS; t++) begin : gen_tgt
    assign tgt_o[t].req   = mgr_i.req && !hold && (sel == target_idx_t'(t));
    assign tgt_o[t].addr  = mgr_i.addr;
    assign tgt_o[t].we    = mgr_i.we;
    assign tgt_o[t].be    = mgr_i.be;
    assign tgt_o[t].wdata = mgr_i.wdata;

    assign tgt_gnt[t]    = tgt_o[t].gnt;
    assign tgt_rvalid[t] = tgt_o[t].rvalid;
    assign tgt_rdata[t]  = tgt_o[t].rdata;
  end

  assign mgr_i.gnt = tgt_gnt[sel] && !hold;
  assign accept    = mgr_i.req && mgr_i.gnt;

  // Responses come from the remembered target
  assign mgr_i.rvalid = tgt_rvalid[tgt_q];
  assign mgr_i.rdata  = tgt_rdata[tgt_q];

  // Outstanding tracking
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : outst_regs
    if (!rst_ni) begin
      cnt_q <= '0;
      tgt_q <= TARGET_EXT_IDX;
    end else begin
      case ({accept, mgr_i.rvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      if (accept) begin
        tgt_q <= sel;
      end
    end
  end

  // No target answers a request this demux never issued
  a_rvalid_with_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|tgt_rvalid) |-> (cnt_q != '0)
  );

  // Only the target of the pending transactions may answer
  a_rvalid_from_tgt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|tgt_rvalid) |-> tgt_rvalid[tgt_q]
  );

endmodule

`default_nettype wire

/* obi_if.sv */
// One OBI channel
// Manager and subordinate modports

`timescale 1ns/1ps
`default_nettype none

interface obi_if
  import obi_pkg::*;
();

  // Request phase
  logic      req;
  logic      gnt;
  obi_addr_t addr;
  logic      we;
  obi_be_t   be;
  obi_data_t wdata;

  // Response phase
  logic      rvalid;
  obi_data_t rdata;

  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

/* bus_map_pkg.sv */
// Manager and target counts of the peripheral bus
// Fixed address map rule and outstanding transaction limit

`default_nettype none

package bus_map_pkg;
  import obi_pkg::*;

  localparam int unsigned NUM_MANAGERS = 2;
  localparam int unsigned NUM_TARGETS  = 2;

  typedef logic [$clog2(NUM_MANAGERS)-1:0] mgr_idx_t;
  typedef logic [$clog2(NUM_TARGETS)-1:0]  target_idx_t;

  // Demux outputs
  localparam target_idx_t TARGET_SRAM_IDX = 1'b0;
  localparam target_idx_t TARGET_EXT_IDX  = 1'b1;

  // SRAM region
  // --------------------
  localparam obi_addr_t   SRAM_BASE  = 32'h0000_0000;
  localparam int unsigned SRAM_SIZE  = 4096;
  localparam int unsigned SRAM_WORDS = SRAM_SIZE / OBI_BE_W;
  localparam int unsigned SRAM_IDX_W = $clog2(SRAM_WORDS);

  typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

  // Transactions in flight per demux and per arbiter
  localparam int unsigned MAX_OUTSTANDING = 4;

  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] outst_cnt_t;
  typedef logic [$clog2(MAX_OUTSTANDING)-1:0]   qptr_t;

  // Anything outside the SRAM window goes to the external port
  function automatic target_idx_t addr_to_target(obi_addr_t addr);
    obi_addr_t offset;
    offset = addr - SRAM_BASE;
    return (offset < obi_addr_t'(SRAM_SIZE)) ? TARGET_SRAM_IDX : TARGET_EXT_IDX;
  endfunction

endpackage

`default_nettype wire

/* obi_pkg.sv */
// OBI channel field widths
// Address, data and byte enable types

`default_nettype none

package obi_pkg;

  localparam int unsigned OBI_ADDR_W = 32;
  localparam int unsigned OBI_DATA_W = 32;
  localparam int unsigned OBI_BE_W   = OBI_DATA_W / 8;

  // Address bits below the word index
  localparam int unsigned OBI_BYTE_OFS_W = $clog2(OBI_BE_W);

  // Bus fields
  // --------------------
  typedef logic [OBI_ADDR_W-1:0] obi_addr_t;
  typedef logic [OBI_DATA_W-1:0] obi_data_t;
  typedef logic [OBI_BE_W-1:0]   obi_be_t;

endpackage

`default_nettype wire
